/* verilog/desc_buffer_cfg_pkg.sv */
package desc_buffer_cfg_pkg;

    ////////////////////
    // Slot geometry
    ////////////////////

    // Bits per descriptor element
    localparam int element_width = 8;
    // Elements carried by one slot
    localparam int simd = 8;
    localparam int elements_per_descriptor = 32;
    // Four slots make one descriptor
    localparam int slots_per_descriptor = elements_per_descriptor / simd;
    localparam int slot_index_width = $clog2(slots_per_descriptor);
    localparam int slot_data_width = element_width * simd;

    ////////////////////
    // Buffer depth
    ////////////////////

    // Keypoints held at once
    localparam int keypoint_depth = 16;
    localparam int keypoint_index_width = $clog2(keypoint_depth);
    // One entry per slot
    localparam int entry_depth = keypoint_depth * slots_per_descriptor;
    localparam int entry_address_width = $clog2(entry_depth);
    // Width of the load count and keypoint totals
    localparam int count_width = 16;

    // Read side state, empty until an unread entry exists
    typedef enum logic {
        read_empty,
        read_ready
    } read_state_t;

endpackage

/* verilog/desc_info_pkg.sv */
package desc_info_pkg;

    ////////////////////
    // Metadata fields
    ////////////////////

    // Cell id taken from the load port
    localparam int cell_id_width = 8;
    // Running keypoint id, cleared by reset only
    localparam int keypoint_id_width = 10;
    // Type field, always written as zero here
    localparam int info_type_width = 2;

    // Metadata word stored beside every slot
    // Most significant field first
    typedef struct packed {
        logic [cell_id_width-1:0]                        cell_id;
        logic [info_type_width-1:0]                      info_type;
        logic [keypoint_id_width-1:0]                    keypoint_id;
        // Keypoint position flags
        logic                                            keypoint_last;
        logic                                            keypoint_first;
        // Slot position flags
        logic                                            slot_last;
        logic                                            slot_first;
        // Slot inside its descriptor
        logic [desc_buffer_cfg_pkg::slot_index_width-1:0] slot_index;
    } desc_info_t;

    // Packed size of the metadata word, 26 bits
    localparam int info_width = $bits(desc_info_t);

endpackage

/* verilog/slot_position_if.sv */
`timescale 1ns/1ps

// Slot and keypoint position with its boundary flags
interface slot_position_if;

    // Slot inside the current keypoint
    logic [desc_buffer_cfg_pkg::slot_index_width-1:0]     slot_index;
    logic                                                  slot_first;
    logic                                                  slot_last;

    // Keypoint inside the buffer
    logic [desc_buffer_cfg_pkg::keypoint_index_width-1:0] keypoint_index;
    logic                                                  keypoint_first;
    logic                                                  keypoint_last;

    // Owner of the position
    modport counter (
        output slot_index,
        output slot_first,
        output slot_last,
        output keypoint_index,
        output keypoint_first,
        output keypoint_last
    );

    // Anyone that only looks at it
    modport user (
        input slot_index,
        input slot_first,
        input slot_last,
        input keypoint_index,
        input keypoint_first,
        input keypoint_last
    );

endinterface

/* verilog/slot_keypoint_counter.sv */
`timescale 1ns/1ps

// Two-level position counter, slots inside keypoints
// Keypoint index wraps after keypoint_limit keypoints
module slot_keypoint_counter (
    input  logic                                        buffer_load_clk,
    input  logic                                        rst,
    input  logic                                        clear,
    input  logic                                        step,
    input  logic [desc_buffer_cfg_pkg::count_width-1:0] keypoint_limit,
    slot_position_if.counter                            pos
);

    ////////////////////
    // Position registers
    ////////////////////

    logic [desc_buffer_cfg_pkg::slot_index_width-1:0]     slot_index;
    logic [desc_buffer_cfg_pkg::keypoint_index_width-1:0] keypoint_index;

    // Flags decoded from the indices
    logic slot_first;
    logic slot_last;
    logic keypoint_first;
    logic keypoint_last;

    // Last slot of a descriptor, index 3
    assign slot_first = (slot_index == '0);
    assign slot_last  = (slot_index ==
        desc_buffer_cfg_pkg::slot_index_width'(desc_buffer_cfg_pkg::slots_per_descriptor - 1));

    // Keypoint index widened to the limit width for the compare
    // A zero limit never matches, so no early wrap
    assign keypoint_first = (keypoint_index == '0);
    assign keypoint_last  =
        (desc_buffer_cfg_pkg::count_width'(keypoint_index) ==
         keypoint_limit - desc_buffer_cfg_pkg::count_width'(1));

    always_ff @(posedge buffer_load_clk) begin
        if (rst || clear) begin
            slot_index     <= '0;
            keypoint_index <= '0;
        end else if (step) begin
            if (slot_last) begin
                // Descriptor done, move to next keypoint
                slot_index <= '0;
                if (keypoint_last) begin
                    // Past the last keypoint, back to 0
                    keypoint_index <= '0;
                end else begin
                    keypoint_index <= keypoint_index + 1'b1;
                end
            end else begin
                slot_index <= slot_index + 1'b1;
            end
        end
    end

    ////////////////////
    // Drive the interface
    ////////////////////

    assign pos.slot_index     = slot_index;
    assign pos.slot_first     = slot_first;
    assign pos.slot_last      = slot_last;
    assign pos.keypoint_index = keypoint_index;
    assign pos.keypoint_first = keypoint_first;
    assign pos.keypoint_last  = keypoint_last;

endmodule

/* verilog/read_sequencer.sv */
`timescale 1ns/1ps

// Tracks what is loaded and decides when a read may proceed
module read_sequencer (
    input  logic                                                buffer_load_clk,
    input  logic                                                rst,
    input  logic                                                load_clear,
    input  logic                                                load_write,
    input  logic                                                advance_request,
    slot_position_if.user                                       read_pos,
    output logic                                                advance,
    output logic [desc_buffer_cfg_pkg::entry_address_width:0]   entry_count,
    output logic [desc_buffer_cfg_pkg::count_width-1:0]         keypoints_loaded,
    output logic                                                buffer_empty,
    output logic                                                buffer_read_valid
);

    desc_buffer_cfg_pkg::read_state_t state;

    logic [desc_buffer_cfg_pkg::entry_address_width-1:0] read_address;
    logic                                                keypoint_complete;
    logic                                                entries_waiting;

    // Same address the entry store reads from
    assign read_address = {read_pos.keypoint_index, read_pos.slot_index};

    // Fourth slot of a keypoint, count low bits all ones before the write
    assign keypoint_complete =
        load_write && (entry_count[desc_buffer_cfg_pkg::slot_index_width-1:0] == '1);

    // Unread entries beyond the read address
    assign entries_waiting = (entry_count > {1'b0, read_address});

    ////////////////////
    // Load bookkeeping
    ////////////////////

    always_ff @(posedge buffer_load_clk) begin
        if (rst || load_clear) begin
            entry_count      <= '0;
            keypoints_loaded <= '0;
        end else begin
            if (load_write) begin
                entry_count <= entry_count + 1'b1;
            end
            // Whole keypoints only, read counter wraps on this
            if (keypoint_complete) begin
                keypoints_loaded <= keypoints_loaded + 1'b1;
            end
        end
    end

    ////////////////////
    // Read FSM
    ////////////////////

    // Follows the compare one cycle late
    always_ff @(posedge buffer_load_clk) begin
        if (rst) begin
            state <= desc_buffer_cfg_pkg::read_empty;
        end else if (entries_waiting) begin
            state <= desc_buffer_cfg_pkg::read_ready;
        end else begin
            state <= desc_buffer_cfg_pkg::read_empty;
        end
    end

    // Requests dropped while empty
    assign advance      = advance_request && (state == desc_buffer_cfg_pkg::read_ready);
    assign buffer_empty = (state == desc_buffer_cfg_pkg::read_empty);

    // Data comes out of the registered read one cycle after advance
    always_ff @(posedge buffer_load_clk) begin
        if (rst) begin
            buffer_read_valid <= 1'b0;
        end else begin
            buffer_read_valid <= advance;
        end
    end

endmodule

/* verilog/descriptor_entry_store.sv */
`timescale 1ns/1ps

// Slot memory with metadata, one entry per slot
module descriptor_entry_store (
    input  logic                                            buffer_load_clk,
    input  logic                                            rst,
    input  logic                                            write,
    input  logic [desc_info_pkg::cell_id_width-1:0]         load_cell_id,
    input  logic [desc_buffer_cfg_pkg::slot_data_width-1:0] load_data,
    slot_position_if.user                                   load_pos,
    slot_position_if.user                                   read_pos,
    output logic [desc_buffer_cfg_pkg::slot_data_width-1:0] read_data,
    output desc_info_pkg::desc_info_t                       read_info
);

    // Entry is data on top, metadata below
    localparam int entry_width =
        desc_buffer_cfg_pkg::slot_data_width + desc_info_pkg::info_width;

    logic [entry_width-1:0] entries [desc_buffer_cfg_pkg::entry_depth];
    logic [entry_width-1:0] read_entry;
    logic [entry_width-1:0] write_entry;

    logic [desc_info_pkg::keypoint_id_width-1:0]         keypoint_id;
    desc_info_pkg::desc_info_t                           load_info;
    logic [desc_buffer_cfg_pkg::entry_address_width-1:0] write_address;
    logic [desc_buffer_cfg_pkg::entry_address_width-1:0] read_address;

    ////////////////////
    // Keypoint id
    ////////////////////

    // Keeps counting across load init
    // Steps once the last slot of a keypoint goes in
    always_ff @(posedge buffer_load_clk) begin
        if (rst) begin
            keypoint_id <= '0;
        end else if (write && load_pos.slot_last) begin
            keypoint_id <= keypoint_id + 1'b1;
        end
    end

    ////////////////////
    // Entry packing
    ////////////////////

    always_comb begin
        load_info.cell_id        = load_cell_id;
        load_info.info_type      = '0;
        load_info.keypoint_id    = keypoint_id;
        load_info.keypoint_last  = load_pos.keypoint_last;
        load_info.keypoint_first = load_pos.keypoint_first;
        load_info.slot_last      = load_pos.slot_last;
        load_info.slot_first     = load_pos.slot_first;
        load_info.slot_index     = load_pos.slot_index;
    end

    assign write_entry = {load_data, load_info};

    // Keypoint times four plus slot
    assign write_address = {load_pos.keypoint_index, load_pos.slot_index};
    assign read_address  = {read_pos.keypoint_index, read_pos.slot_index};

    ////////////////////
    // Memory
    ////////////////////

    always_ff @(posedge buffer_load_clk) begin
        if (write) begin
            entries[write_address] <= write_entry;
        end
    end

    // Registered read, every cycle
    always_ff @(posedge buffer_load_clk) begin
        read_entry <= entries[read_address];
    end

    // Split back into payload and metadata
    assign read_data = read_entry[entry_width-1:desc_info_pkg::info_width];
    assign read_info = desc_info_pkg::desc_info_t'(read_entry[desc_info_pkg::info_width-1:0]);

endmodule

/* verilog/descriptor_buffer_top.sv */
`timescale 1ns/1ps

// Circular descriptor buffer on one clock for load and read
module descriptor_buffer_top (
    input  logic                                            buffer_load_clk,
    input  logic                                            rst,

    // Load side
    input  logic                                            buffer_load_init,
    input  logic                                            buffer_load_valid,
    input  logic [desc_info_pkg::cell_id_width-1:0]         buffer_load_cell_id,
    input  logic [desc_buffer_cfg_pkg::slot_data_width-1:0] buffer_load_data,
    input  logic [desc_buffer_cfg_pkg::count_width-1:0]     buffer_load_count,

    // Read side
    input  logic                                            buffer_read_init,
    input  logic                                            buffer_read_advance,
    output logic [desc_buffer_cfg_pkg::slot_data_width-1:0] buffer_read_data,
    output desc_info_pkg::desc_info_t                       buffer_read_info,
    output logic                                            buffer_read_valid,
    output logic                                            buffer_empty
);

    ////////////////////
    // Internal wires
    ////////////////////

    // Accepted advance that steps the read counter
    logic                                              read_advance;
    // Whole keypoints loaded as the read wrap limit
    logic [desc_buffer_cfg_pkg::count_width-1:0]       keypoints_loaded;

    // Position buses
    slot_position_if load_pos ();
    slot_position_if read_pos ();

    ////////////////////
    // Load position
    ////////////////////

    // Wraps after buffer_load_count keypoints
    slot_keypoint_counter load_counter (
        .buffer_load_clk (buffer_load_clk),
        .rst             (rst),
        .clear           (buffer_load_init),
        .step            (buffer_load_valid),
        .keypoint_limit  (buffer_load_count),
        .pos             (load_pos.counter)
    );

    ////////////////////
    // Read position
    ////////////////////

    // Wraps after the last complete keypoint
    slot_keypoint_counter read_counter (
        .buffer_load_clk (buffer_load_clk),
        .rst             (rst),
        .clear           (buffer_read_init),
        .step            (read_advance),
        .keypoint_limit  (keypoints_loaded),
        .pos             (read_pos.counter)
    );

    ////////////////////
    // Read control
    ////////////////////

    read_sequencer sequencer (
        .buffer_load_clk   (buffer_load_clk),
        .rst               (rst),
        .load_clear        (buffer_load_init),
        .load_write        (buffer_load_valid),
        .advance_request   (buffer_read_advance),
        .read_pos          (read_pos.user),
        .advance           (read_advance),
        .entry_count       (),
        .keypoints_loaded  (keypoints_loaded),
        .buffer_empty      (buffer_empty),
        .buffer_read_valid (buffer_read_valid)
    );

    ////////////////////
    // Storage
    ////////////////////

    // Write on every valid and read at the read position
    descriptor_entry_store store (
        .buffer_load_clk (buffer_load_clk),
        .rst             (rst),
        .write           (buffer_load_valid),
        .load_cell_id    (buffer_load_cell_id),
        .load_data       (buffer_load_data),
        .load_pos        (load_pos.user),
        .read_pos        (read_pos.user),
        .read_data       (buffer_read_data),
        .read_info       (buffer_read_info)
    );

endmodule

/* tb/descriptor_buffer_tests.svh */
////////////////////
// Directed tests
////////////////////

// Idle after reset and deaf to advance while empty
task automatic check_reset_state();
    expect_flag(buffer_empty, 1'b1, "buffer_empty after reset");
    expect_flag(buffer_read_valid, 1'b0, "buffer_read_valid after reset");
    @(negedge buffer_load_clk);
    buffer_read_advance = 1'b1;
    @(negedge buffer_load_clk);
    buffer_read_advance = 1'b0;
    // Watch a few cycles for a stray valid
    for (int cycle = 0; cycle < 4; cycle++) begin
        expect_flag(buffer_read_valid, 1'b0, "valid after advance while empty");
        expect_flag(buffer_empty, 1'b1, "buffer_empty with nothing loaded");
        @(negedge buffer_load_clk);
    end
endtask

// Three keypoints in and twelve slots out in write order
// Info compare covers slot flags, keypoint flags, id, cell id and type
task automatic load_and_read_back();
    load_keypoints(3, 8'h5a);
    wait_empty_level(1'b0, "after first load");
    for (int index = 0; index < 12; index++) begin
        read_and_check(index, $sformatf("first pass slot %0d", index));
    end
    // Empty register sees the wrapped read address one cycle later
    @(negedge buffer_load_clk);
    expect_flag(buffer_empty, 1'b0, "buffer_empty after wrap");
endtask

// Past keypoint 2 the read position is back at keypoint 0 slot 0
task automatic read_wraps_to_start();
    read_and_check(0, "wrapped slot 0");
    expect_flag(buffer_read_info.slot_first, 1'b1, "slot_first after wrap");
    expect_flag(buffer_read_info.keypoint_first, 1'b1, "keypoint_first after wrap");
    read_and_check(1, "wrapped slot 1");
    read_and_check(2, "wrapped slot 2");
endtask

// Read init, load init, then a reload with a new cell id
task automatic init_and_reload();
    int first_id;
    // Back to the start from mid keypoint
    restart_reading();
    read_and_check(0, "slot 0 after read init");
    read_and_check(1, "slot 1 after read init");

    // Entry count cleared and buffer reports empty
    clear_loading();
    wait_empty_level(1'b1, "after load init");
    expect_flag(buffer_empty, 1'b1, "buffer_empty after load init");
    restart_reading();

    // Id keeps counting from the first load
    first_id = model_keypoint_id;
    load_keypoints(3, 8'hc3);
    wait_empty_level(1'b0, "after reload");
    for (int index = 0; index < 12; index++) begin
        read_and_check(index, $sformatf("reload slot %0d", index));
        if (index == 0 && buffer_read_info.keypoint_id !==
                desc_info_pkg::keypoint_id_width'(first_id)) begin
            mismatch_count++;
            $display("Mismatch at %0t: keypoint_id restarted, got %0d expected %0d",
                     $time, buffer_read_info.keypoint_id, first_id);
        end
    end

    // And the reload wraps too
    read_and_check(0, "reload wrapped slot 0");
endtask

/* tb/descriptor_buffer_tb.sv */
`timescale 1ns/1ps

module descriptor_buffer_tb;

    // Cycles any single wait may take
    localparam int wait_limit = 32;

    logic                                            buffer_load_clk;
    logic                                            rst;
    logic                                            buffer_load_init;
    logic                                            buffer_load_valid;
    logic [desc_info_pkg::cell_id_width-1:0]         buffer_load_cell_id;
    logic [desc_buffer_cfg_pkg::slot_data_width-1:0] buffer_load_data;
    logic [desc_buffer_cfg_pkg::count_width-1:0]     buffer_load_count;
    logic                                            buffer_read_init;
    logic                                            buffer_read_advance;
    logic [desc_buffer_cfg_pkg::slot_data_width-1:0] buffer_read_data;
    desc_info_pkg::desc_info_t                       buffer_read_info;
    logic                                            buffer_read_valid;
    logic                                            buffer_empty;

    // Error tallies
    int mismatch_count;
    int timeout_count;
    integer seed;

    // Expected entries by address, and the running keypoint id
    logic [desc_buffer_cfg_pkg::slot_data_width-1:0] model_data [desc_buffer_cfg_pkg::entry_depth];
    desc_info_pkg::desc_info_t                       model_info [desc_buffer_cfg_pkg::entry_depth];
    int                                              model_keypoint_id;

    descriptor_buffer_top UUT (
        .buffer_load_clk     (buffer_load_clk),
        .rst                 (rst),
        .buffer_load_init    (buffer_load_init),
        .buffer_load_valid   (buffer_load_valid),
        .buffer_load_cell_id (buffer_load_cell_id),
        .buffer_load_data    (buffer_load_data),
        .buffer_load_count   (buffer_load_count),
        .buffer_read_init    (buffer_read_init),
        .buffer_read_advance (buffer_read_advance),
        .buffer_read_data    (buffer_read_data),
        .buffer_read_info    (buffer_read_info),
        .buffer_read_valid   (buffer_read_valid),
        .buffer_empty        (buffer_empty)
    );

    // 8 ns clock
    initial begin
        buffer_load_clk = 1'b0;
        forever begin
            #4 buffer_load_clk = ~buffer_load_clk;
        end
    end

    ////////////////////
    // Compare tasks
    ////////////////////

    task automatic compare_data(input logic [desc_buffer_cfg_pkg::slot_data_width-1:0] actual,
                                input logic [desc_buffer_cfg_pkg::slot_data_width-1:0] expected,
                                input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s data got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic verify_info(input desc_info_pkg::desc_info_t actual,
                               input desc_info_pkg::desc_info_t expected,
                               input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s info got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic expect_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, what, actual, expected);
        end
    endtask

    ////////////////////
    // Model and drivers
    ////////////////////

    // Metadata word for one slot, straight from the field rules
    function automatic desc_info_pkg::desc_info_t expected_info(
        input int slot,
        input int keypoint,
        input int keypoints,
        input int keypoint_id,
        input logic [desc_info_pkg::cell_id_width-1:0] cell_id
    );
        desc_info_pkg::desc_info_t info;
        info.cell_id        = cell_id;
        info.info_type      = '0;
        info.keypoint_id    = desc_info_pkg::keypoint_id_width'(keypoint_id);
        info.keypoint_last  = (keypoint == keypoints - 1);
        info.keypoint_first = (keypoint == 0);
        info.slot_last      = (slot == 3);
        info.slot_first     = (slot == 0);
        info.slot_index     = desc_buffer_cfg_pkg::slot_index_width'(slot);
        return info;
    endfunction

    // Back to back slots from load position 0, model filled alongside
    task automatic load_keypoints(input int keypoints,
                                  input logic [desc_info_pkg::cell_id_width-1:0] cell_id);
        int index;
        logic [desc_buffer_cfg_pkg::slot_data_width-1:0] data;
        for (int kp = 0; kp < keypoints; kp++) begin
            for (int slot = 0; slot < 4; slot++) begin
                data = {$random(seed), $random(seed)};
                index = kp * 4 + slot;
                model_data[index] = data;
                model_info[index] = expected_info(slot, kp, keypoints, model_keypoint_id, cell_id);
                @(negedge buffer_load_clk);
                buffer_load_valid   = 1'b1;
                buffer_load_data    = data;
                buffer_load_cell_id = cell_id;
                buffer_load_count   = desc_buffer_cfg_pkg::count_width'(keypoints);
                // Id moves on once the fourth slot is in
                if (slot == 3) begin
                    model_keypoint_id++;
                end
            end
        end
        @(negedge buffer_load_clk);
        buffer_load_valid = 1'b0;
    endtask

    task automatic wait_empty_level(input logic level, input string what);
        int waited;
        waited = 0;
        while (buffer_empty !== level && waited < wait_limit) begin
            @(negedge buffer_load_clk);
            waited++;
        end
        if (buffer_empty !== level) begin
            timeout_count++;
            $display("Timeout at %0t: buffer_empty never became %0b %s", $time, level, what);
        end
    endtask

    // One advance pulse, then wait for the valid cycle
    task automatic read_and_check(input int index, input string what);
        int waited;
        waited = 0;
        @(negedge buffer_load_clk);
        buffer_read_advance = 1'b1;
        @(negedge buffer_load_clk);
        buffer_read_advance = 1'b0;
        while (!buffer_read_valid && waited < wait_limit) begin
            @(negedge buffer_load_clk);
            waited++;
        end
        if (!buffer_read_valid) begin
            timeout_count++;
            $display("Timeout at %0t: no read valid for %s", $time, what);
        end else begin
            compare_data(buffer_read_data, model_data[index], what);
            verify_info(buffer_read_info, model_info[index], what);
        end
    endtask

    task automatic restart_reading();
        @(negedge buffer_load_clk);
        buffer_read_init = 1'b1;
        @(negedge buffer_load_clk);
        buffer_read_init = 1'b0;
    endtask

    task automatic clear_loading();
        @(negedge buffer_load_clk);
        buffer_load_init = 1'b1;
        @(negedge buffer_load_clk);
        buffer_load_init = 1'b0;
    endtask

    `include "descriptor_buffer_tests.svh"

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        seed                = 32'h3593682a;
        mismatch_count      = 0;
        timeout_count       = 0;
        model_keypoint_id   = 0;
        rst                 = 1'b1;
        buffer_load_init    = 1'b0;
        buffer_load_valid   = 1'b0;
        buffer_load_cell_id = '0;
        buffer_load_data    = '0;
        buffer_load_count   = '0;
        buffer_read_init    = 1'b0;
        buffer_read_advance = 1'b0;
        repeat (16) @(negedge buffer_load_clk);
        rst = 1'b0;
        @(negedge buffer_load_clk);

        check_reset_state();
        load_and_read_back();
        read_wraps_to_start();
        init_and_reload();

        $display("Summary: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* build.f */
verilog/desc_buffer_cfg_pkg.sv
verilog/desc_info_pkg.sv
verilog/slot_position_if.sv
verilog/slot_keypoint_counter.sv
verilog/read_sequencer.sv
verilog/descriptor_entry_store.sv
verilog/descriptor_buffer_top.sv
+incdir+tb
tb/descriptor_buffer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the descriptor buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module descriptor_buffer_tb -f build.f \
    -Mdir obj_dir -o descriptor_buffer_sim > sim.log 2>&1 \
    && ./obj_dir/descriptor_buffer_sim >> sim.log 2>&1 \
    || { cat sim.log; echo "Build or simulation error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failure"
exit 0
